/* Makefile */
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= dcache_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dcache_top.f */
+incdir+rtl
rtl/cache_pkg.sv
rtl/tag_lookup_if.sv
rtl/tag_store.sv
rtl/line_ram.sv
rtl/flush_counter.sv
rtl/cache_ctrl_fsm.sv
rtl/dcache_top.sv
verification/dcache_tb.sv

/* rtl/cache_ctrl_fsm.sv */
// aligned 64-bit accesses only; one request at a time, memory side moves whole 128-bit lines
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module cache_ctrl_fsm
    import cache_pkg::*;
(
    input wire                      clk,
    input wire                      rst,
    input wire                      req_valid_i,
    input wire cache_op_e           req_op_i,
    input wire  [`ADDR_W-1:0]       req_addr_i,
    input wire  [`WORD_W-1:0]       req_wdata_i,
    input wire  [(`WORD_W/8)-1:0]   req_wmask_i,
    output logic                    req_ready_o,
    output logic                    resp_valid_o,
    output logic [`WORD_W-1:0]      resp_rdata_o,
    output logic                    mem_valid_o,
    output logic                    mem_we_o,
    output logic [`ADDR_W-1:0]      mem_addr_o,
    output logic [`LINE_W-1:0]      mem_wdata_o,
    input wire                      mem_ready_i,
    input wire  [`LINE_W-1:0]       mem_rdata_i,
    tag_lookup_if.ctrl              tl,
    output logic [`INDEX_W-1:0]     ram_index_o,
    output logic [(`LINE_W/8)-1:0]  ram_we_lanes_o,
    output logic [`LINE_W-1:0]      ram_wdata_o,
    input wire  [`LINE_W-1:0]       ram_rdata_i,
    output logic                    flush_clear_o,
    output logic                    flush_step_o,
    input wire  [`INDEX_W-1:0]      flush_count_i,
    input wire                      flush_last_i
);

    ctrl_state_e            state_q;
    ctrl_state_e            state_d;
    cache_op_e              op_q;
    logic [`ADDR_W-1:0]     addr_q;
    word_t                  wdata_q;
    logic [(`WORD_W/8)-1:0] wmask_q;
    index_t                 req_index;
    tag_t                   req_tag;
    index_t                 line_index;
    logic                   accept;
    logic                   victim_dirty;
    logic                   in_flush;

    assign req_ready_o  = (state_q == S_IDLE);
    assign accept       = req_valid_i && req_ready_o;
    assign req_index    = addr_q[`OFFSET_W +: `INDEX_W];
    assign req_tag      = addr_q[`ADDR_W-1 -: `TAG_W];
    assign victim_dirty = tl.valid_bit && tl.dirty_bit;
    assign in_flush     = (state_q == S_FLUSH_CHECK) || (state_q == S_FLUSH_WRITE);
    assign line_index   = in_flush ? flush_count_i : req_index;

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= req_op_i;
            addr_q  <= req_addr_i;
            wdata_q <= req_wdata_i;
            wmask_q <= req_wmask_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (accept) begin
                    state_d = (req_op_i == OP_FLUSH) ? S_FLUSH_CHECK : S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (tl.hit) state_d = S_RESPOND;
                else if (victim_dirty) state_d = S_WRITEBACK;
                else state_d = S_FILL;
            end
            S_RESPOND:   state_d = S_IDLE;
            S_WRITEBACK: if (mem_ready_i) state_d = S_FILL;
            S_FILL:      if (mem_ready_i) state_d = S_LOOKUP;  // look up again, now a hit
            S_FLUSH_CHECK: begin
                if (victim_dirty) state_d = S_FLUSH_WRITE;
                else if (flush_last_i) state_d = S_FLUSH_DONE;
            end
            S_FLUSH_WRITE: begin
                if (mem_ready_i) state_d = flush_last_i ? S_FLUSH_DONE : S_FLUSH_CHECK;
            end
            S_FLUSH_DONE: state_d = S_IDLE;
            default:      state_d = S_IDLE;
        endcase
    end

    // tag store and line RAM steering
    assign tl.index       = line_index;
    assign tl.tag         = req_tag;
    assign tl.update_fill = (state_q == S_FILL) && mem_ready_i;
    assign tl.set_dirty   = (state_q == S_RESPOND) && (op_q == OP_WRITE);
    assign tl.clear_dirty = (state_q == S_FLUSH_WRITE) && mem_ready_i;

    assign ram_index_o = line_index;

    always_comb begin
        ram_we_lanes_o = '0;
        ram_wdata_o    = {wdata_q, wdata_q};  // lanes pick the addressed half
        if (tl.update_fill) begin
            ram_we_lanes_o = '1;
            ram_wdata_o    = mem_rdata_i;
        end else if (tl.set_dirty) begin
            if (addr_q[`OFFSET_W-1]) ram_we_lanes_o = {wmask_q, {(`WORD_W/8){1'b0}}};
            else ram_we_lanes_o = {{(`WORD_W/8){1'b0}}, wmask_q};
        end
    end

    assign flush_clear_o = (state_q == S_IDLE);
    assign flush_step_o  = !flush_last_i &&
                           (((state_q == S_FLUSH_CHECK) && !victim_dirty) ||
                            ((state_q == S_FLUSH_WRITE) && mem_ready_i));

    // memory side, held stable by state until mem_ready_i
    always_comb begin
        mem_valid_o = 1'b0;
        mem_we_o    = 1'b0;
        mem_addr_o  = {req_tag, req_index, {`OFFSET_W{1'b0}}};
        mem_wdata_o = ram_rdata_i;
        case (state_q)
            S_WRITEBACK, S_FLUSH_WRITE: begin
                mem_valid_o = 1'b1;
                mem_we_o    = 1'b1;
                mem_addr_o  = {tl.stored_tag, line_index, {`OFFSET_W{1'b0}}};
            end
            S_FILL:  mem_valid_o = 1'b1;
            default: mem_valid_o = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= (state_q == S_RESPOND) || (state_q == S_FLUSH_DONE);
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_RESPOND) begin
            resp_rdata_o <= addr_q[`OFFSET_W-1] ? ram_rdata_i[`WORD_W +: `WORD_W]
                                                : ram_rdata_i[0 +: `WORD_W];
        end
    end

    mem_hold_a: assert property (@(posedge clk) disable iff (rst)
        mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_addr_o));

    resp_pulse_a: assert property (@(posedge clk) disable iff (rst)
        resp_valid_o |=> !resp_valid_o);

endmodule

`default_nettype wire

/* rtl/cache_macros.svh */
// line count must be a power of two; line and word widths are fixed at 128 and 64 bits
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

`define CACHE_LINES 16
`define ADDR_W      64
`define LINE_W      128
`define WORD_W      64
`define OFFSET_W    4

// derived address fields
`define INDEX_W     $clog2(`CACHE_LINES)
`define TAG_W       (`ADDR_W - `INDEX_W - `OFFSET_W)

`endif

/* rtl/cache_pkg.sv */
// field types follow cache_macros.svh; opcode 2'b11 is not defined and is handled as a read
`default_nettype none
`include "cache_macros.svh"

package cache_pkg;

    typedef enum logic [1:0] {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1,
        OP_FLUSH = 2'd2
    } cache_op_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_RESPOND,
        S_WRITEBACK,
        S_FILL,
        S_FLUSH_CHECK,
        S_FLUSH_WRITE,
        S_FLUSH_DONE
    } ctrl_state_e;

    typedef logic [`INDEX_W-1:0] index_t;
    typedef logic [`TAG_W-1:0]   tag_t;
    typedef logic [`LINE_W-1:0]  line_t;
    typedef logic [`WORD_W-1:0]  word_t;

endpackage

`default_nettype wire

/* rtl/dcache_top.sv */
// direct mapped write-back data cache; memory must return a whole line on each read transfer
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module dcache_top
    import cache_pkg::*;
(
    input wire                      clk,
    input wire                      rst,
    input wire                      req_valid_i,
    input wire cache_op_e           req_op_i,
    input wire  [`ADDR_W-1:0]       req_addr_i,
    input wire  [`WORD_W-1:0]       req_wdata_i,
    input wire  [(`WORD_W/8)-1:0]   req_wmask_i,
    output logic                    req_ready_o,
    output logic                    resp_valid_o,
    output logic [`WORD_W-1:0]      resp_rdata_o,
    output logic                    mem_valid_o,
    output logic                    mem_we_o,
    output logic [`ADDR_W-1:0]      mem_addr_o,
    output logic [`LINE_W-1:0]      mem_wdata_o,
    input wire                      mem_ready_i,
    input wire  [`LINE_W-1:0]       mem_rdata_i
);

    logic [`INDEX_W-1:0]    ram_index;
    logic [(`LINE_W/8)-1:0] ram_we_lanes;
    logic [`LINE_W-1:0]     ram_wdata;
    logic [`LINE_W-1:0]     ram_rdata;
    logic                   flush_clear;
    logic                   flush_step;
    logic [`INDEX_W-1:0]    flush_count;
    logic                   flush_last;

    tag_lookup_if tl ();

    cache_ctrl_fsm u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req_valid_i    (req_valid_i),
        .req_op_i       (req_op_i),
        .req_addr_i     (req_addr_i),
        .req_wdata_i    (req_wdata_i),
        .req_wmask_i    (req_wmask_i),
        .req_ready_o    (req_ready_o),
        .resp_valid_o   (resp_valid_o),
        .resp_rdata_o   (resp_rdata_o),
        .mem_valid_o    (mem_valid_o),
        .mem_we_o       (mem_we_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_ready_i    (mem_ready_i),
        .mem_rdata_i    (mem_rdata_i),
        .tl             (tl),
        .ram_index_o    (ram_index),
        .ram_we_lanes_o (ram_we_lanes),
        .ram_wdata_o    (ram_wdata),
        .ram_rdata_i    (ram_rdata),
        .flush_clear_o  (flush_clear),
        .flush_step_o   (flush_step),
        .flush_count_i  (flush_count),
        .flush_last_i   (flush_last)
    );

    tag_store u_tags (
        .clk (clk),
        .rst (rst),
        .tl  (tl)
    );

    line_ram u_lines (
        .clk        (clk),
        .index_i    (ram_index),
        .we_lanes_i (ram_we_lanes),
        .wdata_i    (ram_wdata),
        .rdata_o    (ram_rdata)
    );

    flush_counter u_flush (
        .clk     (clk),
        .rst     (rst),
        .clear_i (flush_clear),
        .step_i  (flush_step),
        .count_o (flush_count),
        .last_o  (flush_last)
    );

endmodule

`default_nettype wire

/* rtl/flush_counter.sv */
// counts up from zero; last_o relies on the line count being a power of two
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module flush_counter (
    input wire                  clk,
    input wire                  rst,
    input wire                  clear_i,
    input wire                  step_i,
    output logic [`INDEX_W-1:0] count_o,
    output logic                last_o
);

    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            count_o <= '0;
        end else if (step_i) begin
            count_o <= count_o + 1'b1;
        end
    end

    assign last_o = &count_o;  // all ones is the final index

    step_clear_a: assert property (@(posedge clk) disable iff (rst)
        !(step_i && clear_i));

endmodule

`default_nettype wire

/* rtl/line_ram.sv */
// behavioral single port RAM, read data valid one cycle after the index, old data on a write
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module line_ram (
    input wire                      clk,
    input wire  [`INDEX_W-1:0]      index_i,
    input wire  [(`LINE_W/8)-1:0]   we_lanes_i,
    input wire  [`LINE_W-1:0]       wdata_i,
    output logic [`LINE_W-1:0]      rdata_o
);

    localparam int LANES = `LINE_W / 8;

    logic [`LINE_W-1:0] mem_q [`CACHE_LINES];

    // byte lane writes
    always_ff @(posedge clk) begin
        for (int b = 0; b < LANES; b++) begin
            if (we_lanes_i[b]) begin
                mem_q[index_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
        end
    end

    // registered read
    always_ff @(posedge clk) begin
        rdata_o <= mem_q[index_i];
    end

endmodule

`default_nettype wire

/* rtl/tag_lookup_if.sv */
// lookup results are combinational from index and tag; the strobes take effect at the next edge
`timescale 1ns/1ps
`default_nettype none

interface tag_lookup_if
    import cache_pkg::*;
();

    index_t index;
    tag_t   tag;
    logic   hit;
    logic   valid_bit;
    logic   dirty_bit;
    tag_t   stored_tag;
    logic   update_fill;  // fill done, record tag
    logic   set_dirty;
    logic   clear_dirty;

    modport ctrl (
        output index, tag, update_fill, set_dirty, clear_dirty,
        input  hit, valid_bit, dirty_bit, stored_tag
    );

    modport store (
        input  index, tag, update_fill, set_dirty, clear_dirty,
        output hit, valid_bit, dirty_bit, stored_tag
    );

endinterface

`default_nettype wire

/* rtl/tag_store.sv */
// direct mapped, one entry per line; tags are not reset, so a tag is only meaningful when valid
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module tag_store
    import cache_pkg::*;
(
    input wire          clk,
    input wire          rst,
    tag_lookup_if.store tl
);

    logic [`CACHE_LINES-1:0] valid_q;
    logic [`CACHE_LINES-1:0] dirty_q;
    tag_t                    tag_q [`CACHE_LINES];

    // lookup
    assign tl.valid_bit  = valid_q[tl.index];
    assign tl.dirty_bit  = dirty_q[tl.index];
    assign tl.stored_tag = tag_q[tl.index];
    assign tl.hit        = valid_q[tl.index] && (tag_q[tl.index] == tl.tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (tl.update_fill) begin
                valid_q[tl.index] <= 1'b1;
                dirty_q[tl.index] <= 1'b0;  // fresh line from memory
            end
            if (tl.set_dirty) begin
                dirty_q[tl.index] <= 1'b1;
            end
            if (tl.clear_dirty) begin
                dirty_q[tl.index] <= 1'b0;  // written back by flush
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tl.update_fill) begin
            tag_q[tl.index] <= tl.tag;
        end
    end

    // strobes come from different controller states
    dirty_excl_a: assert property (@(posedge clk) disable iff (rst)
        !(tl.set_dirty && tl.clear_dirty));

endmodule

`default_nettype wire

/* verification/dcache_tb.sv */
// one request at a time; memory model answers whole lines, stalls only in the random test
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module dcache_tb
    import cache_pkg::*;
();

    localparam int TIMEOUT  = 5000;  // cycles per wait
    localparam int N_RANDOM = 200;

    logic                   clk;
    logic                   rst;
    logic                   req_valid_i;
    cache_op_e              req_op_i;
    logic [`ADDR_W-1:0]     req_addr_i;
    logic [`WORD_W-1:0]     req_wdata_i;
    logic [(`WORD_W/8)-1:0] req_wmask_i;
    logic                   req_ready_o;
    logic                   resp_valid_o;
    logic [`WORD_W-1:0]     resp_rdata_o;
    logic                   mem_valid_o;
    logic                   mem_we_o;
    logic [`ADDR_W-1:0]     mem_addr_o;
    logic [`LINE_W-1:0]     mem_wdata_o;
    logic                   mem_ready_i;
    logic [`LINE_W-1:0]     mem_rdata_i;

    logic [31:0]  lfsr_q;
    logic [63:0]  flat [logic [63:0]];       // processor view by word address
    logic [127:0] mem_lines [logic [63:0]];  // lines written back so far
    logic         xfer_we_q [$];
    logic [63:0]  xfer_addr_q [$];
    logic [127:0] xfer_data_q [$];
    logic [63:0]  exp_q [$];
    logic         is_read_q [$];
    int           accept_q [$];
    int           lat_q [$];
    int           edge_cnt = 0;
    int           resp_seen;
    int           checks;
    int           errors;
    int           errors_at_start;
    bit           stall_en;
    string        test_name;

    dcache_top dut (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;
    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[62:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return r;
    endfunction

    // power-on contents, mixes every address bit
    function automatic logic [63:0] init_word(logic [63:0] a);
        return (a * 64'h9e37_79b9_7f4a_7c15) ^ {a[31:0], a[63:32]};
    endfunction

    function automatic logic [127:0] mem_line(logic [63:0] la);
        if (mem_lines.exists(la)) return mem_lines[la];
        return {init_word(la | 64'h8), init_word(la)};
    endfunction

    // expected word as the processor should see it
    function automatic logic [63:0] ref_word(logic [63:0] a);
        if (flat.exists(a)) return flat[a];
        return init_word(a);
    endfunction

    function automatic logic [63:0] merge_word(logic [63:0] old, logic [63:0] wd, logic [7:0] m);
        logic [63:0] r;
        r = old;
        for (int b = 0; b < 8; b++) begin
            if (m[b]) r[b*8 +: 8] = wd[b*8 +: 8];
        end
        return r;
    endfunction

    function automatic int count_writes();
        int c;
        c = 0;
        foreach (xfer_we_q[i]) begin
            if (xfer_we_q[i]) c++;
        end
        return c;
    endfunction

    task automatic compare_values(string what, logic [127:0] expected, logic [127:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s %s: expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic abort_on_timeout(string what);
        $display("ERROR: test %s timed out waiting for %s", test_name, what);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic start_test(string name);
        test_name = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        $display("test %s: done, %0d errors", test_name, errors - errors_at_start);
    endtask

    task automatic clear_log();
        xfer_we_q.delete();
        xfer_addr_q.delete();
        xfer_data_q.delete();
    endtask

    // memory model, decides ready and moves the line for the coming edge
    always @(negedge clk) begin
        mem_ready_i = 1'b0;
        if (!rst && mem_valid_o) begin
            if (!stall_en || rand_bits(1) != 64'd0) begin
                mem_ready_i = 1'b1;
                xfer_we_q.push_back(mem_we_o);
                xfer_addr_q.push_back(mem_addr_o);
                xfer_data_q.push_back(mem_we_o ? mem_wdata_o : mem_line(mem_addr_o));
                if (mem_we_o) mem_lines[mem_addr_o] = mem_wdata_o;
                else mem_rdata_i = mem_line(mem_addr_o);
            end
        end
    end

    // response checker
    always @(negedge clk) begin
        if (!rst && resp_valid_o) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("ERROR: test %s got a response with no request pending", test_name);
            end else begin
                if (is_read_q[0]) compare_values("read data", exp_q[0], resp_rdata_o);
                if (lat_q[0] >= 0) compare_values("latency", lat_q[0], edge_cnt - accept_q[0]);
                void'(exp_q.pop_front());
                void'(is_read_q.pop_front());
                void'(lat_q.pop_front());
                void'(accept_q.pop_front());
                resp_seen++;
            end
        end
    end

    // starts and ends on a falling edge; lat < 0 skips the latency check
    task automatic issue(cache_op_e op, logic [63:0] addr, logic [63:0] wd, logic [7:0] m,
                         int lat);
        int n;
        int seen;
        n = 0;
        while (!req_ready_o) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) abort_on_timeout("req_ready_o");
        end
        seen = resp_seen;
        exp_q.push_back(op == OP_READ ? ref_word(addr) : 64'd0);
        is_read_q.push_back(op == OP_READ);
        lat_q.push_back(lat);
        accept_q.push_back(edge_cnt + 1);
        if (op == OP_WRITE) flat[addr] = merge_word(ref_word(addr), wd, m);
        req_valid_i = 1'b1;
        req_op_i    = op;
        req_addr_i  = addr;
        req_wdata_i = wd;
        req_wmask_i = m;
        @(negedge clk);
        req_valid_i = 1'b0;
        n = 0;
        while (resp_seen == seen) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) abort_on_timeout("resp_valid_o");
        end
    endtask

    initial begin
        logic [63:0]  a;
        logic [63:0]  b;
        logic [63:0]  wd;
        logic [7:0]   m;
        logic [2:0]   sel;
        logic [127:0] ln;
        lfsr_q      = 32'h4a2cca80;
        rst         = 1'b1;
        req_valid_i = 1'b0;
        req_op_i    = OP_READ;
        req_addr_i  = '0;
        req_wdata_i = '0;
        req_wmask_i = '0;
        mem_ready_i = 1'b0;
        mem_rdata_i = '0;
        stall_en    = 1'b0;
        checks      = 0;
        errors      = 0;
        resp_seen   = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test("reset");
        compare_values("req_ready_o", 1, req_ready_o);
        compare_values("resp_valid_o", 0, resp_valid_o);
        compare_values("mem_valid_o", 0, mem_valid_o);
        end_test();

        start_test("cold_reads");
        issue(OP_READ, 64'h1000_0000, 0, 0, -1);
        issue(OP_READ, 64'h1000_0008, 0, 0, -1);
        issue(OP_READ, 64'h1000_0120, 0, 0, -1);
        issue(OP_READ, 64'h1000_0238, 0, 0, -1);
        end_test();

        start_test("hit_timing");
        a = 64'h1000_0040;
        issue(OP_READ, a, 0, 0, -1);
        issue(OP_READ, a, 0, 0, 2);
        issue(OP_WRITE, a, 64'h1122_3344_5566_7788, 8'b1010_0101, 2);
        issue(OP_READ, a, 0, 0, 2);
        issue(OP_READ, a + 64'h8, 0, 0, 2);  // other half, same line
        end_test();

        start_test("victim_writeback");
        a = 64'h1000_0098;  // index 9
        b = a + 64'h1_0000;
        issue(OP_WRITE, a, 64'hdead_beef_0bad_f00d, 8'hf0, -1);
        clear_log();
        issue(OP_READ, b, 0, 0, -1);
        compare_values("memory writes", 1, count_writes());
        compare_values("transfers", 2, xfer_we_q.size());
        if (xfer_we_q.size() == 2) begin
            a = a & ~64'hf;
            compare_values("first is write", 1, xfer_we_q[0]);
            compare_values("writeback addr", a, xfer_addr_q[0]);
            compare_values("writeback line", {ref_word(a | 64'h8), ref_word(a)}, xfer_data_q[0]);
            compare_values("second is read", 0, xfer_we_q[1]);
            compare_values("fill addr", b & ~64'hf, xfer_addr_q[1]);
        end
        end_test();

        start_test("flush");
        issue(OP_FLUSH, 0, 0, 0, -1);  // start from a clean cache
        issue(OP_WRITE, 64'h2000_0010, 64'h0101_0202_0303_0404, 8'hff, -1);
        issue(OP_WRITE, 64'h2000_0038, 64'h5555_6666_7777_8888, 8'h3c, -1);
        issue(OP_WRITE, 64'h2000_0050, 64'hcafe_cafe_cafe_cafe, 8'h01, -1);
        issue(OP_READ, 64'h2000_0060, 0, 0, -1);
        clear_log();
        issue(OP_FLUSH, 0, 0, 0, -1);
        compare_values("memory writes", 3, count_writes());
        compare_values("transfers", 3, xfer_we_q.size());
        foreach (xfer_we_q[i]) begin
            a = xfer_addr_q[i];
            compare_values("flushed line", {ref_word(a | 64'h8), ref_word(a)}, xfer_data_q[i]);
        end
        clear_log();
        issue(OP_FLUSH, 0, 0, 0, -1);
        compare_values("second flush writes", 0, count_writes());
        end_test();

        start_test("random_mix");
        stall_en = 1'b1;
        for (int i = 0; i < N_RANDOM; i++) begin
            sel = 3'(rand_bits(3));
            a = 64'h4000_0000;
            a[9:8] = 2'(rand_bits(2));  // few tags, many conflicts
            a[7:4] = 4'(rand_bits(4));
            a[3]   = 1'(rand_bits(1));
            if (sel == 3'd7) begin
                issue(OP_FLUSH, 0, 0, 0, -1);
            end else if (sel >= 3'd4) begin
                wd = rand_bits(64);
                m  = 8'(rand_bits(8));
                issue(OP_WRITE, a, wd, m, -1);
            end else begin
                issue(OP_READ, a, 0, 0, -1);
            end
        end
        issue(OP_FLUSH, 0, 0, 0, -1);
        foreach (flat[w]) begin
            ln = mem_line(w & ~64'hf);
            compare_values("memory word", flat[w], w[3] ? ln[127:64] : ln[63:0]);
        end
        end_test();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
